// File: source/elastic_pkg.sv
// Payload layouts are fixed here; DATA_WIDTH changes every channel width at once
package elastic_pkg;

  // Width of one operand or result value
  parameter int DATA_WIDTH = 32;

  // Opcodes carried on stream a
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_AND = 2'd2,
    OP_XOR = 2'd3
  } alu_op_t;

  // Stream a token with opcode and left operand (34 bits)
  typedef struct packed {
    alu_op_t               op;
    logic [DATA_WIDTH-1:0] value;
  } a_token_t;

  // Stream b token holding the right operand only (32 bits)
  typedef struct packed {
    logic [DATA_WIDTH-1:0] value;
  } b_token_t;

  // Joined pair handed to the ALU (66 bits)
  typedef struct packed {
    a_token_t a;
    b_token_t b;
  } pair_t;

  // Result channel payload (33 bits)
  typedef struct packed {
    logic [DATA_WIDTH-1:0] value;
    // Set when value is all zero
    logic                  zero;
  } result_t;

endpackage

// File: source/elastic_fifo_inner.sv
// Circular FIFO of NUM_SLOTS words; NUM_SLOTS must be 1 or more, memory has no reset
`timescale 1ns/1ps

module elastic_fifo_inner #(
  parameter int NUM_SLOTS = 2,
  parameter int WIDTH     = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] ins,
  input  logic             ins_valid,
  input  logic             outs_ready,
  output logic [WIDTH-1:0] outs,
  output logic             outs_valid,
  output logic             ins_ready
);

  // One-bit pointers still needed for a single slot
  localparam int PTR_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

  logic [WIDTH-1:0] mem [NUM_SLOTS];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] head_next;
  logic [PTR_W-1:0] tail_next;
  logic             full;
  logic             empty;
  logic             write_en;
  logic             read_en;

  // Space available, or a slot frees up this cycle
  assign ins_ready  = ~full | outs_ready;
  assign outs_valid = ~empty;
  assign outs       = mem[head];

  assign write_en = ins_valid & ins_ready;
  assign read_en  = outs_ready & ~empty;

  // Wrapping increments
  assign head_next = (head == PTR_W'(NUM_SLOTS - 1)) ? '0 : head + 1'b1;
  assign tail_next = (tail == PTR_W'(NUM_SLOTS - 1)) ? '0 : tail + 1'b1;

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[tail] <= ins;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail <= '0;
    end else if (write_en) begin
      tail <= tail_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (read_en) begin
      head <= head_next;
    end
  end

  // Flags move only on a one-sided access
  always_ff @(posedge clk) begin
    if (rst) begin
      full  <= 1'b0;
      empty <= 1'b1;
    end else if (write_en && !read_en) begin
      empty <= 1'b0;
      // Tail catching up with head
      if (tail_next == head) begin
        full <= 1'b1;
      end
    end else if (read_en && !write_en) begin
      full <= 1'b0;
      if (head_next == tail) begin
        empty <= 1'b1;
      end
    end
  end

endmodule

// File: source/tfifo.sv
// Transparent FIFO; zero latency when empty, holds NUM_SLOTS tokens behind a stalled consumer
`timescale 1ns/1ps

module tfifo #(
  parameter int NUM_SLOTS = 2,
  parameter int WIDTH     = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] ins,
  input  logic             ins_valid,
  input  logic             outs_ready,
  output logic [WIDTH-1:0] outs,
  output logic             outs_valid,
  output logic             ins_ready
);

  logic [WIDTH-1:0] fifo_out;
  logic             fifo_valid;
  logic             fifo_ready;
  logic             fifo_in_valid;

  // Buffer only if the consumer stalls or older tokens wait
  assign fifo_in_valid = ins_valid & (~outs_ready | fifo_valid);

  // Queued tokens go first to keep arrival order
  assign outs       = fifo_valid ? fifo_out : ins;
  assign outs_valid = ins_valid | fifo_valid;
  assign ins_ready  = fifo_ready | outs_ready;

  elastic_fifo_inner #(
    .NUM_SLOTS (NUM_SLOTS),
    .WIDTH     (WIDTH)
  ) fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .ins        (ins),
    .ins_valid  (fifo_in_valid),
    .outs_ready (outs_ready),
    .outs       (fifo_out),
    .outs_valid (fifo_valid),
    .ins_ready  (fifo_ready)
  );

endmodule

// File: source/elastic_join.sv
// Combinational join of streams a and b; neither side advances without its partner
`timescale 1ns/1ps

module elastic_join (
  input  logic                 a_valid,
  input  elastic_pkg::a_token_t a_data,
  output logic                 a_ready,
  input  logic                 b_valid,
  input  elastic_pkg::b_token_t b_data,
  output logic                 b_ready,
  output logic                 out_valid,
  output elastic_pkg::pair_t    out_data,
  input  logic                 out_ready
);

  // Fire only with both tokens present
  assign out_valid = a_valid & b_valid;

  // Each side waits on its partner and the consumer
  assign a_ready = b_valid & out_ready;
  assign b_ready = a_valid & out_ready;

  assign out_data.a = a_data;
  assign out_data.b = b_data;

endmodule

// File: source/elastic_alu.sv
// Single-cycle ALU with a one-slot output register; result valid one cycle after acceptance
`timescale 1ns/1ps

module elastic_alu (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  elastic_pkg::pair_t   in_data,
  output logic                in_ready,
  output logic                res_valid,
  output elastic_pkg::result_t res_data,
  input  logic                res_ready
);

  logic [elastic_pkg::DATA_WIDTH-1:0] op_a;
  logic [elastic_pkg::DATA_WIDTH-1:0] op_b;
  elastic_pkg::result_t               result;
  logic                               load;

  assign op_a = in_data.a.value;
  assign op_b = in_data.b.value;

  always_comb begin
    result.value = '0;
    case (in_data.a.op)
      elastic_pkg::OP_ADD: result.value = op_a + op_b;
      elastic_pkg::OP_SUB: result.value = op_a - op_b;
      elastic_pkg::OP_AND: result.value = op_a & op_b;
      elastic_pkg::OP_XOR: result.value = op_a ^ op_b;
      default:             result.value = '0;
    endcase
    result.zero = (result.value == '0);
  end

  // Slot is free when empty or draining this cycle
  assign in_ready = ~res_valid | res_ready;
  assign load     = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (load) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (load) begin
      res_data <= result;
    end
  end

endmodule

// File: source/dataflow_kernel.sv
// Two transparent FIFOs feeding a join and an ALU; FIFO depths must be 1 or more
`timescale 1ns/1ps

module dataflow_kernel #(
  parameter int A_SLOTS = 2,
  parameter int B_SLOTS = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  a_valid,
  input  elastic_pkg::a_token_t  a_data,
  output logic                  a_ready,
  input  logic                  b_valid,
  input  elastic_pkg::b_token_t  b_data,
  output logic                  b_ready,
  output logic                  res_valid,
  output elastic_pkg::result_t   res_data,
  input  logic                  res_ready
);

  // FIFO word widths follow the token layouts
  localparam int A_WIDTH = $bits(elastic_pkg::a_token_t);
  localparam int B_WIDTH = $bits(elastic_pkg::b_token_t);

  logic [A_WIDTH-1:0]    a_word;
  logic [B_WIDTH-1:0]    b_word;
  elastic_pkg::a_token_t a_tok;
  elastic_pkg::b_token_t b_tok;
  logic                  a_tok_valid;
  logic                  b_tok_valid;
  logic                  a_tok_ready;
  logic                  b_tok_ready;
  elastic_pkg::pair_t    pair;
  logic                  pair_valid;
  logic                  pair_ready;

  assign a_tok = elastic_pkg::a_token_t'(a_word);
  assign b_tok = elastic_pkg::b_token_t'(b_word);

  tfifo #(
    .NUM_SLOTS (A_SLOTS),
    .WIDTH     (A_WIDTH)
  ) a_fifo (
    .clk        (clk),
    .rst        (rst),
    .ins        (A_WIDTH'(a_data)),
    .ins_valid  (a_valid),
    .outs_ready (a_tok_ready),
    .outs       (a_word),
    .outs_valid (a_tok_valid),
    .ins_ready  (a_ready)
  );

  tfifo #(
    .NUM_SLOTS (B_SLOTS),
    .WIDTH     (B_WIDTH)
  ) b_fifo (
    .clk        (clk),
    .rst        (rst),
    .ins        (B_WIDTH'(b_data)),
    .ins_valid  (b_valid),
    .outs_ready (b_tok_ready),
    .outs       (b_word),
    .outs_valid (b_tok_valid),
    .ins_ready  (b_ready)
  );

  elastic_join join_inst (
    .a_valid   (a_tok_valid),
    .a_data    (a_tok),
    .a_ready   (a_tok_ready),
    .b_valid   (b_tok_valid),
    .b_data    (b_tok),
    .b_ready   (b_tok_ready),
    .out_valid (pair_valid),
    .out_data  (pair),
    .out_ready (pair_ready)
  );

  elastic_alu alu_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pair_valid),
    .in_data   (pair),
    .in_ready  (pair_ready),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_ready (res_ready)
  );

endmodule

// File: test/dataflow_kernel_asserts.sv
// Result channel protocol checks bound into dataflow_kernel; sampled on the rising clk edge
`timescale 1ns/1ps

module dataflow_kernel_asserts (
  input logic                 clk,
  input logic                 rst,
  input logic                 res_valid,
  input logic                 res_ready,
  input elastic_pkg::result_t res_data
);

  // Register is cleared by any reset edge
  property reset_clears_valid;
    @(posedge clk) rst |=> !res_valid;
  endproperty

  // Payload frozen while the consumer stalls
  property data_stable_when_stalled;
    @(posedge clk) disable iff (rst)
      (res_valid && !res_ready) |=> $stable(res_data);
  endproperty

  // No retraction of an offered result
  property valid_held_until_taken;
    @(posedge clk) disable iff (rst)
      (res_valid && !res_ready) |=> res_valid;
  endproperty

  reset_clears_valid_check: assert property (reset_clears_valid)
    else $error("res_valid is high during reset");

  data_stable_check: assert property (data_stable_when_stalled)
    else $error("res_data changed while res_valid was high and res_ready low");

  valid_held_check: assert property (valid_held_until_taken)
    else $error("res_valid dropped before the result was accepted");

endmodule

bind dataflow_kernel dataflow_kernel_asserts asserts_inst (
  .clk       (clk),
  .rst       (rst),
  .res_valid (res_valid),
  .res_ready (res_ready),
  .res_data  (res_data)
);

// File: test/dataflow_kernel_tb.sv
// Fixed-seed random testbench for dataflow_kernel; stops at the first error, FIFO depths set below
`timescale 1ns/1ps

module dataflow_kernel_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int A_SLOTS      = 2;
  localparam int B_SLOTS      = 3;
  localparam int RANDOM_HALF  = 250;
  localparam int ZERO_PAIRS   = 16;
  localparam int FILL_PAIRS   = ((A_SLOTS > B_SLOTS) ? A_SLOTS : B_SLOTS) + 2;
  localparam int TOTAL_TOKENS = 2 * (1 + ZERO_PAIRS + 2 * RANDOM_HALF + FILL_PAIRS);
  localparam int WATCHDOG_NS  = 20 * TOTAL_TOKENS * CLK_PERIOD;
  localparam int SEED         = 32'h84da;

  // res_ready modes
  localparam int RR_HIGH   = 0;
  localparam int RR_RANDOM = 1;
  localparam int RR_LOW    = 2;

  logic                  clk;
  logic                  rst;
  logic                  a_valid;
  elastic_pkg::a_token_t a_data;
  logic                  a_ready;
  logic                  b_valid;
  elastic_pkg::b_token_t b_data;
  logic                  b_ready;
  logic                  res_valid;
  elastic_pkg::result_t  res_data;
  logic                  res_ready;

  elastic_pkg::a_token_t a_q[$];
  elastic_pkg::b_token_t b_q[$];
  integer                a_seed = SEED;
  integer                b_seed = SEED + 1;
  integer                r_seed = SEED + 2;
  int                    rr_mode = RR_HIGH;

  dataflow_kernel #(
    .A_SLOTS (A_SLOTS),
    .B_SLOTS (B_SLOTS)
  ) dataflow_kernel_inst (
    .clk       (clk),
    .rst       (rst),
    .a_valid   (a_valid),
    .a_data    (a_data),
    .a_ready   (a_ready),
    .b_valid   (b_valid),
    .b_data    (b_data),
    .b_ready   (b_ready),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_ready (res_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Expected result straight from the opcode rules
  function automatic elastic_pkg::result_t alu_model(input elastic_pkg::a_token_t ta,
                                                     input elastic_pkg::b_token_t tb);
    elastic_pkg::result_t r;
    if (ta.op == elastic_pkg::OP_ADD) begin
      r.value = ta.value + tb.value;
    end else if (ta.op == elastic_pkg::OP_SUB) begin
      r.value = ta.value - tb.value;
    end else if (ta.op == elastic_pkg::OP_AND) begin
      r.value = ta.value & tb.value;
    end else begin
      r.value = ta.value ^ tb.value;
    end
    r.zero = ~|r.value;
    return r;
  endfunction

  task automatic check_result(input elastic_pkg::result_t expected,
                              input elastic_pkg::result_t actual);
    if (actual.value !== expected.value) begin
      abort_run($sformatf("ERROR res_data.value expected %h actual %h",
                          expected.value, actual.value));
    end else if (actual.zero !== expected.zero) begin
      abort_run($sformatf("ERROR res_data.zero expected %h actual %h",
                          expected.zero, actual.zero));
    end
  endtask

  task automatic check_ready(input string name, input bit expected, input bit actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic elastic_pkg::a_token_t random_a();
    elastic_pkg::a_token_t tok;
    tok.op    = elastic_pkg::alu_op_t'(2'($random(a_seed)));
    tok.value = $random(a_seed);
    return tok;
  endfunction

  function automatic elastic_pkg::b_token_t random_b();
    elastic_pkg::b_token_t tok;
    tok.value = $random(b_seed);
    return tok;
  endfunction

  // Called at posedge+1, returns at posedge+1 with valid still high
  task automatic drive_a(input elastic_pkg::a_token_t tok, input int gap, input bit at_once);
    if (gap > 0) begin
      a_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    a_data  = tok;
    a_valid = 1'b1;
    @(negedge clk);
    if (at_once) begin
      check_ready("a_ready", 1'b1, a_ready);
    end
    while (!a_ready) begin
      @(negedge clk);
    end
    a_q.push_back(tok);
    @(posedge clk);
    #1;
  endtask

  task automatic drive_b(input elastic_pkg::b_token_t tok, input int gap, input bit at_once);
    if (gap > 0) begin
      b_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    b_data  = tok;
    b_valid = 1'b1;
    @(negedge clk);
    if (at_once) begin
      check_ready("b_ready", 1'b1, b_ready);
    end
    while (!b_ready) begin
      @(negedge clk);
    end
    b_q.push_back(tok);
    @(posedge clk);
    #1;
  endtask

  task automatic send_a(input int n);
    int i;
    elastic_pkg::a_token_t tok;
    int gap;
    for (i = 0; i < n; i++) begin
      tok = random_a();
      gap = $random(a_seed) & 32'h3;
      drive_a(tok, gap, 1'b0);
    end
    a_valid = 1'b0;
  endtask

  task automatic send_b(input int n);
    int i;
    elastic_pkg::b_token_t tok;
    int gap;
    for (i = 0; i < n; i++) begin
      tok = random_b();
      gap = $random(b_seed) & 32'h3;
      drive_b(tok, gap, 1'b0);
    end
    b_valid = 1'b0;
  endtask

  task automatic send_pair(input elastic_pkg::a_token_t ta, input elastic_pkg::b_token_t tb);
    fork
      drive_a(ta, 0, 1'b0);
      drive_b(tb, 0, 1'b0);
    join
    a_valid = 1'b0;
    b_valid = 1'b0;
  endtask

  // n tokens must go in back to back, then the next one must stall
  task automatic fill_a(input int n, output elastic_pkg::a_token_t extra);
    int i;
    for (i = 0; i < n; i++) begin
      drive_a(random_a(), 0, 1'b1);
    end
    extra  = random_a();
    a_data = extra;
    repeat (3) begin
      @(negedge clk);
      check_ready("a_ready", 1'b0, a_ready);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic fill_b(input int n, output elastic_pkg::b_token_t extra);
    int i;
    for (i = 0; i < n; i++) begin
      drive_b(random_b(), 0, 1'b1);
    end
    extra  = random_b();
    b_data = extra;
    repeat (3) begin
      @(negedge clk);
      check_ready("b_ready", 1'b0, b_ready);
      @(posedge clk);
      #1;
    end
  endtask

  // Exits at posedge+1 once every accepted pair has produced its result
  task automatic wait_drain();
    while (a_q.size() != 0 || b_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // Result side back-pressure
  initial begin
    bit next_ready;
    res_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (rr_mode == RR_HIGH) begin
        next_ready = 1'b1;
      end else if (rr_mode == RR_RANDOM) begin
        next_ready = (($random(r_seed) & 32'h3) != 0);
      end else begin
        next_ready = 1'b0;
      end
      @(posedge clk);
      #1;
      res_ready = next_ready;
    end
  end

  // Compare every result transfer against the queued operands
  initial begin
    elastic_pkg::a_token_t ta;
    elastic_pkg::b_token_t tb;
    forever begin
      @(negedge clk);
      if (!rst && res_valid && res_ready) begin
        if (a_q.size() == 0 || b_q.size() == 0) begin
          abort_run("A result was transferred while no accepted pair was pending");
        end else begin
          ta = a_q.pop_front();
          tb = b_q.pop_front();
          check_result(alu_model(ta, tb), res_data);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("Timeout: the run did not finish within %0d ns", WATCHDOG_NS));
  end

  initial begin
    elastic_pkg::a_token_t ta;
    elastic_pkg::b_token_t tb;
    elastic_pkg::a_token_t extra_a;
    elastic_pkg::b_token_t extra_b;
    logic [elastic_pkg::DATA_WIDTH-1:0] x;
    int i;
    rst     = 1'b1;
    a_valid = 1'b0;
    a_data  = '0;
    b_valid = 1'b0;
    b_data  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // Idle levels straight after reset
    @(negedge clk);
    check_ready("res_valid", 1'b0, res_valid);
    check_ready("a_ready", 1'b1, a_ready);
    check_ready("b_ready", 1'b1, b_ready);
    @(posedge clk);
    #1;

    // Pair in cycle n gives res_valid in n+1 on the empty path
    ta      = random_a();
    tb      = random_b();
    a_data  = ta;
    b_data  = tb;
    a_valid = 1'b1;
    b_valid = 1'b1;
    @(negedge clk);
    check_ready("a_ready", 1'b1, a_ready);
    check_ready("b_ready", 1'b1, b_ready);
    check_ready("res_valid", 1'b0, res_valid);
    a_q.push_back(ta);
    b_q.push_back(tb);
    @(posedge clk);
    #1;
    a_valid = 1'b0;
    b_valid = 1'b0;
    @(negedge clk);
    check_ready("res_valid", 1'b1, res_valid);
    @(posedge clk);
    #1;
    wait_drain();

    // Pairs whose result must be zero
    for (i = 0; i < ZERO_PAIRS / 4; i++) begin
      x = $random(a_seed);
      ta.value = x;
      tb.value = x;
      ta.op = elastic_pkg::OP_SUB;
      send_pair(ta, tb);
      ta.op = elastic_pkg::OP_XOR;
      send_pair(ta, tb);
      ta.op = elastic_pkg::OP_ADD;
      tb.value = -x;
      send_pair(ta, tb);
      ta.op = elastic_pkg::OP_AND;
      tb.value = ~x;
      send_pair(ta, tb);
    end
    wait_drain();

    // Random pairs with res_ready high and then under random back-pressure
    fork
      send_a(RANDOM_HALF);
      send_b(RANDOM_HALF);
    join
    wait_drain();
    rr_mode = RR_RANDOM;
    fork
      send_a(RANDOM_HALF);
      send_b(RANDOM_HALF);
    join
    wait_drain();

    // Each stream fills the ALU slot plus its FIFO while results stall
    rr_mode = RR_LOW;
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    fork
      fill_a(A_SLOTS + 1, extra_a);
      fill_b(B_SLOTS + 1, extra_b);
    join
    rr_mode = RR_HIGH;
    fork
      drive_a(extra_a, 0, 1'b0);
      drive_b(extra_b, 0, 1'b0);
    join
    // Partners for the deeper stream
    for (i = A_SLOTS; i < B_SLOTS; i++) begin
      drive_a(random_a(), 0, 1'b0);
    end
    for (i = B_SLOTS; i < A_SLOTS; i++) begin
      drive_b(random_b(), 0, 1'b0);
    end
    a_valid = 1'b0;
    b_valid = 1'b0;
    wait_drain();

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: dataflow_kernel.f
source/elastic_pkg.sv
source/elastic_fifo_inner.sv
source/tfifo.sv
source/elastic_join.sv
source/elastic_alu.sv
source/dataflow_kernel.sv
test/dataflow_kernel_asserts.sv
test/dataflow_kernel_tb.sv

// File: Makefile
TOP = dataflow_kernel_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f dataflow_kernel.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@! grep -q "Test failures found" sim.log
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
